//--- rtl/video_pkg.sv
/* Video raster definitions
   Coordinate and pixel colour types plus the sync pulse level */
package video_pkg;

  // Width of a raster counter or ball coordinate
  localparam int COORD_W = 10;

  // 4 bits per colour channel
  localparam int CHAN_W = 4;

  // Raster position or ball centre
  // 10 bits covers a full 800x525 frame
  typedef logic [COORD_W-1:0] coord_t;

  // Packed pixel colour, red in the top nibble
  // then green, then blue in the low nibble
  typedef logic [3*CHAN_W-1:0] rgb_t;

  // Level of hsync and vsync while the pulse is active
  // Both syncs are negative going in the standard 640x480 mode
  localparam logic SYNC_ACTIVE = 1'b0;

  // Idle level, the opposite of the pulse
  localparam logic SYNC_IDLE = ~SYNC_ACTIVE;

endpackage

//--- rtl/game_pkg.sv
/* Game control definitions
   Register map, write bus types, ball speed and background colour */
package game_pkg;

  // Register write bus
  typedef logic [2:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // Ball step per frame on one axis, always positive
  // Direction lives in a separate flag
  typedef logic [3:0] speed_t;

  // Register map
  // CTRL   bit 0 enables motion
  localparam reg_addr_t ADDR_CTRL   = 3'd0;
  // Start position, writing either one reloads the ball
  localparam reg_addr_t ADDR_BALL_X = 3'd1;
  localparam reg_addr_t ADDR_BALL_Y = 3'd2;
  // SPEED  dx in bits 3:0, dy in bits 7:4
  localparam reg_addr_t ADDR_SPEED  = 3'd3;
  // COLOR  12-bit rgb in bits 11:0
  localparam reg_addr_t ADDR_COLOR  = 3'd4;

  // Bit fields inside the write data
  localparam int CTRL_MOTION_BIT = 0;
  localparam int SPEED_X_LSB     = 0;
  localparam int SPEED_Y_LSB     = 4;

  // Colour of active pixels outside the ball, black
  // Same width as video_pkg::rgb_t
  localparam logic [11:0] BG_COLOR = 12'h000;

endpackage

//--- rtl/raster_timing.sv
/* Raster timing generator
   Pixel and line counters with sync, active area and frame end decode */
`timescale 1ns/1ps

module raster_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic              clk,
  input  logic              arst_n,
  output video_pkg::coord_t screen_x,
  output video_pkg::coord_t screen_y,
  output logic              video_on,
  output logic              hsync_raw,
  output logic              vsync_raw,
  output logic              frame_end
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // Sync windows, start inclusive and end exclusive
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  video_pkg::coord_t h_cnt;
  video_pkg::coord_t v_cnt;
  logic              line_end;

  // Last pixel of the current line
  assign line_end = (h_cnt == video_pkg::coord_t'(H_TOTAL - 1));

  // One pixel per clock, lines advance on the x wrap
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
      // Frame wraps after the last blanking line
      if (v_cnt == video_pkg::coord_t'(V_TOTAL - 1)) v_cnt <= '0;
      else v_cnt <= v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign screen_x = h_cnt;
  assign screen_y = v_cnt;

  // Visible area sits at the start of both counts
  assign video_on = (h_cnt < video_pkg::coord_t'(H_ACTIVE)) &&
                    (v_cnt < video_pkg::coord_t'(V_ACTIVE));

  // Sync pulses inside the blanking intervals
  assign hsync_raw = ((h_cnt >= video_pkg::coord_t'(H_SYNC_START)) &&
                      (h_cnt <  video_pkg::coord_t'(H_SYNC_END))) ?
                     video_pkg::SYNC_ACTIVE : video_pkg::SYNC_IDLE;
  assign vsync_raw = ((v_cnt >= video_pkg::coord_t'(V_SYNC_START)) &&
                      (v_cnt <  video_pkg::coord_t'(V_SYNC_END))) ?
                     video_pkg::SYNC_ACTIVE : video_pkg::SYNC_IDLE;

  // Last pixel of the last line
  assign frame_end = line_end && (v_cnt == video_pkg::coord_t'(V_TOTAL - 1));

endmodule

//--- rtl/game_regs.sv
/* Game control registers
   Strobe-written motion enable, start position, speed and ball colour */
`timescale 1ns/1ps

module game_regs (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 wr_en,
  input  game_pkg::reg_addr_t  wr_addr,
  input  game_pkg::reg_data_t  wr_data,
  output logic                 motion_en,
  output game_pkg::speed_t     speed_x,
  output game_pkg::speed_t     speed_y,
  output video_pkg::rgb_t      ball_color,
  output video_pkg::coord_t    start_x,
  output video_pkg::coord_t    start_y,
  output logic                 load
);

  logic pos_wr;

  // Either start coordinate counts as a position write
  assign pos_wr = wr_en && ((wr_addr == game_pkg::ADDR_BALL_X) ||
                            (wr_addr == game_pkg::ADDR_BALL_Y));

  // Control state, cleared so the ball sits still and invisible
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      motion_en  <= 1'b0;
      speed_x    <= '0;
      speed_y    <= '0;
      ball_color <= '0;
      load       <= 1'b0;
    end else begin
      // Start values are already in place when load fires
      load <= pos_wr;
      if (wr_en) begin
        case (wr_addr)
          game_pkg::ADDR_CTRL:  motion_en <= wr_data[game_pkg::CTRL_MOTION_BIT];
          game_pkg::ADDR_SPEED: begin
            speed_x <= wr_data[game_pkg::SPEED_X_LSB +: 4];
            speed_y <= wr_data[game_pkg::SPEED_Y_LSB +: 4];
          end
          game_pkg::ADDR_COLOR: ball_color <= wr_data[11:0];
          // Unmapped addresses fall through
          default: ;
        endcase
      end
    end
  end

  // Start position only matters once load is seen
  always_ff @(posedge clk) begin
    if (wr_en && (wr_addr == game_pkg::ADDR_BALL_X)) start_x <= wr_data[9:0];
    if (wr_en && (wr_addr == game_pkg::ADDR_BALL_Y)) start_y <= wr_data[9:0];
  end

endmodule

//--- rtl/ball_motion.sv
/* Ball motion
   Steps the ball centre once per frame and bounces it off the field edges */
`timescale 1ns/1ps

module ball_motion #(
  parameter int H_ACTIVE  = 640,
  parameter int V_ACTIVE  = 480,
  parameter int BALL_SIZE = 8
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              frame_end,
  input  logic              motion_en,
  input  game_pkg::speed_t  speed_x,
  input  game_pkg::speed_t  speed_y,
  input  video_pkg::coord_t start_x,
  input  video_pkg::coord_t start_y,
  input  logic              load,
  output video_pkg::coord_t ball_x,
  output video_pkg::coord_t ball_y
);

  localparam int HALF = BALL_SIZE / 2;

  // Direction flags, 1 means increasing coordinate
  logic dir_x;
  logic dir_y;

  // Next direction in the top bit, next centre below it
  logic [video_pkg::COORD_W:0] step_x;
  logic [video_pkg::COORD_W:0] step_y;

  // One axis of the motion rule
  // Ball edge after the step must stay in [0, limit)
  function automatic logic [video_pkg::COORD_W:0] step_axis(
    input video_pkg::coord_t pos,
    input logic              dir,
    input game_pkg::speed_t  spd,
    input int                limit
  );
    int lo;
    int hi;
    lo = int'(pos) - HALF - int'(spd);
    hi = int'(pos) + HALF + int'(spd);
    if (dir) begin
      // Right or bottom edge is exclusive, hi may equal limit
      if (hi > limit) step_axis = {1'b0, pos};
      else step_axis = {1'b1, pos + video_pkg::coord_t'(spd)};
    end else begin
      if (lo < 0) step_axis = {1'b1, pos};
      else step_axis = {1'b0, pos - video_pkg::coord_t'(spd)};
    end
  endfunction

  always_comb begin
    step_x = step_axis(ball_x, dir_x, speed_x, H_ACTIVE);
    step_y = step_axis(ball_y, dir_y, speed_y, V_ACTIVE);
  end

  // Position only changes between frames or on a reload
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ball_x <= video_pkg::coord_t'(H_ACTIVE / 2);
      ball_y <= video_pkg::coord_t'(V_ACTIVE / 2);
      dir_x  <= 1'b1;
      dir_y  <= 1'b1;
    end else if (load) begin
      // Reload wins over a coincident frame end
      ball_x <= start_x;
      ball_y <= start_y;
      dir_x  <= 1'b1;
      dir_y  <= 1'b1;
    end else if (frame_end && motion_en) begin
      // A bounce flips the flag and holds that axis for the frame
      {dir_x, ball_x} <= step_x;
      {dir_y, ball_y} <= step_y;
    end
  end

endmodule

//--- rtl/ball_scan.sv
/* Ball scanner
   Tracks the raster against the ball box with a column countdown and a row flag */
`timescale 1ns/1ps

module ball_scan #(
  parameter int BALL_SIZE = 8,
  // Full line and frame lengths for the next-pixel lookahead
  parameter int H_TOTAL   = 800,
  parameter int V_TOTAL   = 525
) (
  input  logic              clk,
  input  logic              arst_n,
  input  video_pkg::coord_t screen_x,
  input  video_pkg::coord_t screen_y,
  input  video_pkg::coord_t ball_x,
  input  video_pkg::coord_t ball_y,
  output logic              ball_on
);

  localparam video_pkg::coord_t HALF = video_pkg::coord_t'(BALL_SIZE / 2);
  localparam logic [3:0]        SIZE = 4'(BALL_SIZE);

  logic [3:0]        cnt;
  logic              row_flag;
  logic              line_end;
  video_pkg::coord_t next_x;
  video_pkg::coord_t next_y;
  video_pkg::coord_t left_x;
  video_pkg::coord_t top_y;
  video_pkg::coord_t past_bot_y;

  // Ball box edges with the bottom one on the first line below the ball
  assign left_x     = ball_x - HALF;
  assign top_y      = ball_y - HALF;
  assign past_bot_y = ball_y + HALF;

  // Position of the following pixel with line and frame wrap
  assign line_end = (screen_x == video_pkg::coord_t'(H_TOTAL - 1));
  assign next_x   = line_end ? '0 : screen_x + 1'b1;
  assign next_y   = (screen_y == video_pkg::coord_t'(V_TOTAL - 1)) ? '0 : screen_y + 1'b1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt      <= '0;
      row_flag <= 1'b0;
    end else begin
      // Column countdown starts one pixel ahead of the left edge
      if (next_x == left_x) cnt <= SIZE;
      else if (cnt != '0) cnt <= cnt - 1'b1;
      // Row flag switches at line boundaries with the bottom edge first
      if (line_end) begin
        if (next_y == past_bot_y) row_flag <= 1'b0;
        else if (next_y == top_y) row_flag <= 1'b1;
      end
    end
  end

  assign ball_on = (cnt != '0) && row_flag;

  // Countdown stays inside the ball width
  a_cnt_bound: assert property (@(posedge clk) disable iff (!arst_n)
    cnt <= SIZE);

  // Flag only comes up at the first pixel of the ball's top line
  a_flag_rise: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(row_flag) |-> (screen_x == '0) && (screen_y == $past(top_y)));

  // Lit pixels fall inside the ball box
  a_in_box: assert property (@(posedge clk) disable iff (!arst_n)
    ball_on |->
      (video_pkg::coord_t'(screen_x - left_x) < video_pkg::coord_t'(BALL_SIZE)) &&
      (video_pkg::coord_t'(screen_y - top_y) < video_pkg::coord_t'(BALL_SIZE)));

endmodule

//--- rtl/pong_video_top.sv
/* Pong video top level
   Raster timing, control registers, ball motion and scan with a registered pixel output */
`timescale 1ns/1ps

module pong_video_top #(
  parameter int H_ACTIVE  = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int V_ACTIVE  = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33,
  parameter int BALL_SIZE = 8
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                wr_en,
  input  game_pkg::reg_addr_t wr_addr,
  input  game_pkg::reg_data_t wr_data,
  output logic                hsync,
  output logic                vsync,
  output video_pkg::rgb_t     rgb
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  video_pkg::coord_t screen_x, screen_y;
  video_pkg::coord_t ball_x, ball_y;
  video_pkg::coord_t start_x, start_y;
  video_pkg::rgb_t   ball_color, pix;
  game_pkg::speed_t  speed_x, speed_y;
  logic              video_on, hsync_raw, vsync_raw, frame_end;
  logic              motion_en, load, ball_on;

  raster_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) u_raster_timing (
    .clk, .arst_n, .screen_x, .screen_y, .video_on, .hsync_raw, .vsync_raw, .frame_end
  );

  game_regs u_game_regs (
    .clk, .arst_n, .wr_en, .wr_addr, .wr_data,
    .motion_en, .speed_x, .speed_y, .ball_color, .start_x, .start_y, .load
  );

  ball_motion #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .BALL_SIZE(BALL_SIZE)
  ) u_ball_motion (
    .clk, .arst_n, .frame_end, .motion_en, .speed_x, .speed_y,
    .start_x, .start_y, .load, .ball_x, .ball_y
  );

  ball_scan #(
    .BALL_SIZE(BALL_SIZE), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)
  ) u_ball_scan (
    .clk, .arst_n, .screen_x, .screen_y, .ball_x, .ball_y, .ball_on
  );

  // Blanking forces black, ball overrides background
  assign pix = !video_on ? '0 : (ball_on ? ball_color : game_pkg::BG_COLOR);

  // Colour and syncs leave together, one pixel behind the counters
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hsync <= video_pkg::SYNC_IDLE;
      vsync <= video_pkg::SYNC_IDLE;
      rgb   <= '0;
    end else begin
      hsync <= hsync_raw;
      vsync <= vsync_raw;
      rgb   <= pix;
    end
  end

endmodule

//--- tb/tb_pong_video.sv
/* Pong video testbench
   Drives register writes and checks syncs and pixels against a raster and ball model */
`timescale 1ns/1ps

module tb_pong_video;

  localparam int HA = 32, HF = 2, HS = 4, HB = 2;
  localparam int VA = 24, VF = 2, VS = 2, VB = 2;
  localparam int BS = 4;
  localparam int HT = HA + HF + HS + HB;
  localparam int VT = VA + VF + VS + VB;
  localparam int WAIT_LIMIT = 3 * HT * VT;

  logic clk, arst_n, wr_en, hsync, vsync;
  logic [2:0] wr_addr;
  logic [15:0] wr_data;
  logic [11:0] rgb;
  int errors = 0;
  logic [31:0] seed = 32'h6a36_b3ab;
  logic timed_out = 0;
  logic count_on = 0;

  // Model state for the counters and the ball between edges
  int mx = 0, my = 0, mbx = HA / 2, mby = VA / 2, mdx = 1, mdy = 1;
  int sx = 0, sy = 0, spx = 0, spy = 0, mcolor = 0, mmotion = 0, mload = 0;
  int ex, ey, exp_rgb, exp_hs, exp_vs, step, pix_count = 0;
  logic armed = 0;

  pong_video_top #(
    .H_ACTIVE(HA), .H_FRONT(HF), .H_SYNC(HS), .H_BACK(HB),
    .V_ACTIVE(VA), .V_FRONT(VF), .V_SYNC(VS), .V_BACK(VB), .BALL_SIZE(BS)
  ) u_pong_video_top (
    .clk, .arst_n, .wr_en, .wr_addr, .wr_data, .hsync, .vsync, .rgb
  );

  initial begin
    clk = 0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Hit rule and colour rule for one raster position
  function automatic int pixel_color(input int x, input int y, input int bx, input int by,
                                     input int color);
    if (x >= HA || y >= VA) return 0;
    if (x >= bx - BS / 2 && x < bx + BS / 2 && y >= by - BS / 2 && y < by + BS / 2)
      return color;
    return 0;
  endfunction

  // Motion rule for one axis
  // Result holds the new direction times 1024 plus the new centre
  function automatic int axis_step(input int pos, input int dir, input int spd, input int lim);
    int lo_px;
    int hi_px;
    lo_px = (dir != 0) ? pos + spd - BS / 2 : pos - spd - BS / 2;
    hi_px = lo_px + BS - 1;
    // Leaving the field flips the direction and holds the centre
    if (lo_px < 0 || hi_px >= lim) return ((dir != 0) ? 0 : 1024) + pos;
    return ((dir != 0) ? 1024 : 0) + lo_px + BS / 2;
  endfunction

  task automatic check(input string what, input logic [31:0] got,
                       input logic [31:0] expected);
    if (got !== expected) begin
      errors++;
      $display("ERROR %0t: %s got %0h expected %0h", $time, what, got, expected);
    end
  endtask

  // Comparison process that advances the model on each rising edge
  initial begin
    while (arst_n !== 1'b1) begin
      @(negedge clk);
      check("hsync in reset", hsync, 1);
      check("vsync in reset", vsync, 1);
      check("rgb in reset", rgb, 0);
    end
    forever begin
      @(posedge clk);
      ex = mx;
      ey = my;
      exp_rgb = pixel_color(mx, my, mbx, mby, mcolor);
      exp_hs = (mx >= HA + HF && mx < HA + HF + HS) ? 0 : 1;
      exp_vs = (my >= VA + VF && my < VA + VF + VS) ? 0 : 1;
      // Ball update sees register values from before this edge
      if (mload != 0) begin
        mbx = sx;
        mby = sy;
        mdx = 1;
        mdy = 1;
      end else if (mx == HT - 1 && my == VT - 1 && mmotion != 0) begin
        step = axis_step(mbx, mdx, spx, HA);
        mbx = step % 1024;
        mdx = step / 1024;
        step = axis_step(mby, mdy, spy, VA);
        mby = step % 1024;
        mdy = step / 1024;
      end
      mload = (wr_en && (wr_addr == 3'd1 || wr_addr == 3'd2)) ? 1 : 0;
      if (wr_en) begin
        case (wr_addr)
          3'd0: mmotion = wr_data[0];
          3'd1: sx = wr_data[9:0];
          3'd2: sy = wr_data[9:0];
          3'd3: begin
            spx = wr_data[3:0];
            spy = wr_data[7:4];
          end
          3'd4: mcolor = wr_data[11:0];
          default: ;
        endcase
      end
      if (mx == HT - 1) begin
        mx = 0;
        my = (my == VT - 1) ? 0 : my + 1;
      end else mx = mx + 1;
      @(negedge clk);
      check("hsync", hsync, exp_hs);
      check("vsync", vsync, exp_vs);
      check("rgb", rgb, exp_rgb);
      // Ball pixel count per frame
      if (ex == 0 && ey == 0) begin
        if (armed) check("ball pixels per frame", pix_count, BS * BS);
        armed = count_on;
        pix_count = 0;
      end
      if (rgb != 0) pix_count++;
    end
  end

  task automatic reg_write(input logic [2:0] addr, input logic [15:0] data);
    @(posedge clk);
    #1 wr_en = 1'b1;
    wr_addr = addr;
    wr_data = data;
    @(posedge clk);
    #1 wr_en = 1'b0;
  endtask

  // Falling edges of vsync or of hsync
  task automatic wait_sync_falls(input logic vertical, input int count);
    int n;
    logic prev;
    logic seen;
    for (int f = 0; f < count && !timed_out; f++) begin
      n = 0;
      seen = 0;
      while (!seen && n < WAIT_LIMIT) begin
        prev = vertical ? vsync : hsync;
        @(posedge clk);
        #2 seen = prev && !(vertical ? vsync : hsync);
        n++;
      end
      if (!seen) begin
        timed_out = 1;
        errors++;
        $display("Timed out waiting for a falling edge on a sync output");
      end
    end
  endtask

  // New start position written during vertical blanking
  task automatic load_ball(input int x, input int y);
    wait_sync_falls(1'b1, 1);
    reg_write(3'd1, 16'(x));
    reg_write(3'd2, 16'(y));
  endtask

  initial begin
    arst_n = 0;
    wr_en = 0;
    wr_addr = '0;
    wr_data = '0;
    repeat (10) @(posedge clk);
    #1 arst_n = 1;
    wait_sync_falls(1'b1, 2);
    seed = lcg_next(seed);
    reg_write(3'd4, 16'(seed[27:16]) | 16'h001);
    count_on = 1;
    // Still ball at random spots
    // Odd centres keep the box edges off coordinate zero
    for (int i = 0; i < 4; i++) begin
      seed = lcg_next(seed);
      load_ball(3 + 2 * int'(seed[19:16] % 14), 3 + 2 * int'(seed[23:20] % 10));
      wait_sync_falls(1'b1, 2);
    end
    // Moving ball with random even speeds
    reg_write(3'd0, 16'h0001);
    for (int i = 0; i < 3; i++) begin
      seed = lcg_next(seed);
      reg_write(3'd3, {8'h00, seed[22:20], 1'b0, seed[18:16], 1'b0});
      load_ball(3 + 2 * int'(seed[27:24] % 14), 3 + 2 * int'(seed[31:28] % 10));
      wait_sync_falls(1'b1, 8);
    end
    // Bounce off the right and bottom edges and then off the left and top
    reg_write(3'd3, 16'h0022);
    load_ball(29, 21);
    wait_sync_falls(1'b1, 6);
    reg_write(3'd3, 16'h0044);
    load_ball(25, 17);
    wait_sync_falls(1'b1, 12);
    // Ball touching the right and bottom edges of the active area
    reg_write(3'd3, 16'h0000);
    load_ball(30, 22);
    wait_sync_falls(1'b1, 2);
    // Position write on line 12 of a frame
    // The new box starts below that line and the old one was not drawn yet
    wait_sync_falls(1'b0, 17);
    reg_write(3'd1, 16'd9);
    reg_write(3'd2, 16'd17);
    wait_sync_falls(1'b1, 2);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- sim.f
rtl/video_pkg.sv
rtl/game_pkg.sv
rtl/raster_timing.sv
rtl/game_regs.sv
rtl/ball_motion.sv
rtl/ball_scan.sv
rtl/pong_video_top.sv
tb/tb_pong_video.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_pong_video
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
